// ==== design/pedalboard_pkg.sv ====
//******************************
// shared pedalboard definitions
// widths, buffer sizes, knob and bank structs
// sample saturation helper
//******************************

package pedalboard_pkg;

  //******************************
  // sizes
  localparam int DATA_WIDTH      = 16;                 // audio sample width
  localparam int WIDE_WIDTH      = 32;                 // room for sums before clamping
  localparam int ECHO_AWIDTH     = 10;
  localparam int ECHO_DEPTH      = 1 << ECHO_AWIDTH;   // 1024 samples on chip
  localparam int ECHO_TIME_WIDTH = ECHO_AWIDTH + 1;    // echo time reaches full depth
  localparam int TIME_HOLD_TICKS = 64;                 // samples between time reloads
  localparam int TIME_HOLD_WIDTH = $clog2(TIME_HOLD_TICKS);
  localparam int LFO_WIDTH       = 16;                 // tremolo phase accumulator

  // signed two's complement sample
  typedef logic signed [DATA_WIDTH-1:0] sample_t;

  // all knob levels in one word, msb field first
  typedef struct packed {
    logic [7:0] del_time;    // echo time, coarse steps of 4 samples
    logic [7:0] del_level;   // echo return level
    logic [7:0] trem_speed;  // lfo step
    logic [7:0] trem_depth;  // modulation depth
  } knob_levels_t;

  typedef struct packed {
    logic left;   // tremolo bank
    logic right;  // echo bank
  } bank_en_t;

  localparam logic signed [WIDE_WIDTH-1:0] SAMPLE_MAX = 2 ** (DATA_WIDTH - 1) - 1;
  localparam logic signed [WIDE_WIDTH-1:0] SAMPLE_MIN = -(2 ** (DATA_WIDTH - 1));

  // clamp a wide signed value into sample range
  function automatic sample_t sat_sample(input logic signed [WIDE_WIDTH-1:0] sum);
    if (sum > SAMPLE_MAX)
      return sample_t'(SAMPLE_MAX);
    else if (sum < SAMPLE_MIN)
      return sample_t'(SAMPLE_MIN);
    else
      return sum[DATA_WIDTH-1:0];
  endfunction

endpackage

// ==== design/footswitch_ctrl.sv ====
//******************************
// footswitch handling
// edge detect and toggle of both banks
// led drive
//******************************

`timescale 1ns/1ns

module footswitch_ctrl (
  input  logic                     clk_i,
  input  logic                     srst_i,
  input  logic [1:0]               buttons_i,  // [0] left, [1] right
  output pedalboard_pkg::bank_en_t bank_en_o,
  output logic [3:0]               leds_o
);

  import pedalboard_pkg::*;

  logic [1:0] btn_q;       // sampled buttons
  logic [1:0] btn_prev_q;  // previous sample for edge detect
  logic [1:0] btn_rise;
  bank_en_t   bank_en_q;

  assign btn_rise = btn_q & ~btn_prev_q;  // held button gives one pulse only

  //******************************
  // bank toggles
  always_ff @(posedge clk_i)
  begin
    if (srst_i)
    begin
      btn_q      <= '0;
      btn_prev_q <= '0;
      bank_en_q  <= '0;
    end
    else
    begin
      btn_q      <= buttons_i;
      btn_prev_q <= btn_q;
      if (btn_rise[0])
        bank_en_q.left <= !bank_en_q.left;    // tremolo
      if (btn_rise[1])
        bank_en_q.right <= !bank_en_q.right;  // echo
    end
  end

  // two leds per bank, left pair low
  always_ff @(posedge clk_i)
  begin
    if (srst_i)
      leds_o <= '0;
    else
      leds_o <= {bank_en_q.right, bank_en_q.right, bank_en_q.left, bank_en_q.left};
  end

  assign bank_en_o = bank_en_q;

endmodule

// ==== design/echo_delay.sv ====
//******************************
// echo delay with feedback
// on-chip ring buffer, fill tracking
// rate limited time knob
//******************************

`timescale 1ns/1ns

module echo_delay (
  input  logic                    clk_i,
  input  logic                    srst_i,
  input  logic                    sample_tick_i,
  input  logic                    enable_i,
  input  logic [7:0]              del_time_i,
  input  logic [7:0]              del_level_i,
  input  pedalboard_pkg::sample_t data_i,
  output pedalboard_pkg::sample_t data_o
);

  import pedalboard_pkg::*;

  sample_t mem [ECHO_DEPTH];  // ring buffer

  logic [ECHO_AWIDTH-1:0]       wr_ptr_q;     // next slot to write
  logic [ECHO_AWIDTH-1:0]       rd_addr;
  logic [ECHO_TIME_WIDTH-1:0]   knob_time;
  logic [ECHO_TIME_WIDTH-1:0]   echo_time_q;  // active echo time in samples
  logic [ECHO_TIME_WIDTH-1:0]   fill_cnt_q;   // writes since reset, saturating
  logic [TIME_HOLD_WIDTH-1:0]   hold_cnt_q;
  logic                         wr_pend_q;    // second half of a sample
  logic                         en_q;
  logic                         wet_valid_q;
  logic [7:0]                   level_q;
  sample_t                      din_q;
  sample_t                      rd_q;
  sample_t                      wet;
  logic signed [DATA_WIDTH+8:0] wet_prod;
  logic signed [DATA_WIDTH:0]   wet_scaled;
  logic signed [DATA_WIDTH+1:0] mix_sum;
  sample_t                      mix_out;
  sample_t                      wr_data;

  //******************************
  // echo time
  assign knob_time = (ECHO_TIME_WIDTH'(del_time_i) + 1'b1) << 2;  // 4..1024 samples

  always_ff @(posedge clk_i)
  begin
    if (srst_i)
    begin
      echo_time_q <= knob_time;  // first value straight from the knob
      hold_cnt_q  <= '0;
    end
    else if (sample_tick_i)
    begin
      hold_cnt_q <= hold_cnt_q + 1'b1;
      // reload on wrap only, avoids zipper noise while turning
      if (hold_cnt_q == TIME_HOLD_WIDTH'(TIME_HOLD_TICKS - 1))
        echo_time_q <= knob_time;
    end
  end

  //******************************
  // tick stage
  assign rd_addr = wr_ptr_q - echo_time_q[ECHO_AWIDTH-1:0];  // time writes back

  always_ff @(posedge clk_i)
  begin
    if (srst_i)
    begin
      wr_pend_q   <= 1'b0;
      en_q        <= 1'b0;
      wet_valid_q <= 1'b0;
    end
    else
    begin
      wr_pend_q <= sample_tick_i;
      if (sample_tick_i)
      begin
        en_q        <= enable_i;                    // enable takes effect per tick
        wet_valid_q <= (echo_time_q <= fill_cnt_q); // unwritten slot reads as 0
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (sample_tick_i)
    begin
      din_q   <= data_i;
      level_q <= del_level_i;
    end
  end

  // buffer port, read on tick and write one clock later
  always_ff @(posedge clk_i)
  begin
    if (sample_tick_i)
      rd_q <= mem[rd_addr];
    if (wr_pend_q)
      mem[wr_ptr_q] <= wr_data;
  end

  //******************************
  // mix and feedback
  assign wet        = wet_valid_q ? rd_q : '0;
  assign wet_prod   = wet * $signed({1'b0, level_q});
  assign wet_scaled = wet_prod[DATA_WIDTH+8:8];  // arithmetic >>> 8
  assign mix_sum    = din_q + wet_scaled;
  assign mix_out    = en_q ? sat_sample(mix_sum) : din_q;
  assign wr_data    = en_q ? mix_out : '0;        // zeros flush old echoes

  always_ff @(posedge clk_i)
  begin
    if (srst_i)
    begin
      wr_ptr_q   <= '0;
      fill_cnt_q <= '0;
      data_o     <= '0;
    end
    else if (wr_pend_q)
    begin
      wr_ptr_q <= wr_ptr_q + 1'b1;
      if (fill_cnt_q != ECHO_TIME_WIDTH'(ECHO_DEPTH))
        fill_cnt_q <= fill_cnt_q + 1'b1;
      data_o <= mix_out;
    end
  end

  //******************************
  // checks
  // the write half must land before the next tick reads
  a_tick_spacing : assert property (@(posedge clk_i) disable iff (srst_i)
    sample_tick_i |=> !sample_tick_i [*3]);

  a_fill_bound : assert property (@(posedge clk_i) disable iff (srst_i)
    fill_cnt_q <= ECHO_TIME_WIDTH'(ECHO_DEPTH));

endmodule

// ==== design/tremolo.sv ====
//******************************
// tremolo
// triangle lfo scales sample amplitude
//******************************

`timescale 1ns/1ns

module tremolo (
  input  logic                    clk_i,
  input  logic                    srst_i,
  input  logic                    sample_tick_i,
  input  logic                    enable_i,
  input  logic [7:0]              trem_speed_i,
  input  logic [7:0]              trem_depth_i,
  input  pedalboard_pkg::sample_t data_i,
  output pedalboard_pkg::sample_t data_o
);

  import pedalboard_pkg::*;

  logic [LFO_WIDTH-1:0]         phase_q;
  logic [7:0]                   tri_val;     // triangle 0..255
  logic [15:0]                  depth_prod;
  logic [7:0]                   gain;
  logic [7:0]                   gain_q;
  logic                         pend_q;      // output update after tick
  logic                         en_q;
  sample_t                      din_q;
  logic signed [DATA_WIDTH+8:0] amp_prod;
  logic signed [DATA_WIDTH:0]   amp_scaled;

  //******************************
  // lfo
  // second half of the phase counts back down
  assign tri_val = phase_q[LFO_WIDTH-1] ? ~phase_q[LFO_WIDTH-2 -: 8]
                                        : phase_q[LFO_WIDTH-2 -: 8];

  assign depth_prod = trem_depth_i * tri_val;
  assign gain       = 8'd255 - depth_prod[15:8];  // full gain at tri 0

  always_ff @(posedge clk_i)
  begin
    if (srst_i)
      phase_q <= '0;
    else if (!enable_i)
      phase_q <= '0;                                       // restart at enable
    else if (sample_tick_i)
      phase_q <= phase_q + LFO_WIDTH'(trem_speed_i) + 1'b1;
  end

  //******************************
  // sample path
  always_ff @(posedge clk_i)
  begin
    if (srst_i)
    begin
      pend_q <= 1'b0;
      en_q   <= 1'b0;
    end
    else
    begin
      pend_q <= sample_tick_i;
      if (sample_tick_i)
        en_q <= enable_i;
    end
  end

  // gain from the phase before this tick's step
  always_ff @(posedge clk_i)
  begin
    if (sample_tick_i)
    begin
      din_q  <= data_i;
      gain_q <= gain;
    end
  end

  assign amp_prod   = din_q * $signed({1'b0, gain_q});
  assign amp_scaled = amp_prod[DATA_WIDTH+8:8];  // >>> 8

  always_ff @(posedge clk_i)
  begin
    if (srst_i)
      data_o <= '0;
    else if (pend_q)
      data_o <= en_q ? sat_sample(amp_scaled) : din_q;  // bypass when off
  end

  //******************************
  // checks
  a_tick_spacing : assert property (@(posedge clk_i) disable iff (srst_i)
    sample_tick_i |=> !sample_tick_i [*3]);

endmodule

// ==== design/pedalboard.sv ====
//******************************
// pedalboard top
// footswitches, echo then tremolo
//******************************

`timescale 1ns/1ns

module pedalboard (
  input  logic                         clk_i,
  input  logic                         srst_i,
  input  logic                         sample_tick_i,  // one clock strobe per sample
  input  logic [1:0]                   buttons_i,      // [0] left, [1] right
  input  pedalboard_pkg::knob_levels_t knobs_i,
  input  pedalboard_pkg::sample_t      data_i,
  output pedalboard_pkg::sample_t      data_o,
  output logic [3:0]                   leds_o
);

  import pedalboard_pkg::*;

  bank_en_t bank_en;
  sample_t  echo_data;  // echo into tremolo

  footswitch_ctrl u_footswitch (
    .clk_i     ( clk_i     ),
    .srst_i    ( srst_i    ),
    .buttons_i ( buttons_i ),
    .bank_en_o ( bank_en   ),
    .leds_o    ( leds_o    )
  );

  //******************************
  // effect chain
  echo_delay u_echo (
    .clk_i         ( clk_i             ),
    .srst_i        ( srst_i            ),
    .sample_tick_i ( sample_tick_i     ),
    .enable_i      ( bank_en.right     ), // right bank
    .del_time_i    ( knobs_i.del_time  ),
    .del_level_i   ( knobs_i.del_level ),
    .data_i        ( data_i            ),
    .data_o        ( echo_data         )
  );

  // sees the previous tick's echo output
  tremolo u_tremolo (
    .clk_i         ( clk_i              ),
    .srst_i        ( srst_i             ),
    .sample_tick_i ( sample_tick_i      ),
    .enable_i      ( bank_en.left       ), // left bank
    .trem_speed_i  ( knobs_i.trem_speed ),
    .trem_depth_i  ( knobs_i.trem_depth ),
    .data_i        ( echo_data          ),
    .data_o        ( data_o             )
  );

endmodule

// ==== bench/pedalboard_tb.sv ====
//******************************
// pedalboard testbench
// stimulus table, lfsr samples
// reference model of echo and tremolo
//******************************

`timescale 1ns/1ns

module pedalboard_tb;

  import pedalboard_pkg::*;

  localparam int CLK_PERIOD    = 20;
  localparam int RESET_CYCLES  = 4;
  localparam int TICK_CLOCKS   = 8;        // clocks per sample
  localparam int LED_TIMEOUT   = 20;       // clocks allowed for an led change
  localparam int HOLD_CYCLES   = 5;        // footswitch kept down after the toggle
  localparam int NUM_ROWS      = 9;
  localparam int INIT_DEL_TIME = 7;        // time knob seen during reset
  localparam int MAX_SAMPLE    = 32767;
  localparam int MIN_SAMPLE    = -32768;
  localparam logic [15:0] LFSR_SEED = 16'd74;
  localparam logic [15:0] LFSR_TAPS = 16'hB400;  // x^16+x^14+x^13+x^11+1

  // one row of the stimulus table
  typedef struct packed {
    logic [3:0]   left_presses;   // tremolo footswitch
    logic [3:0]   right_presses;  // echo footswitch
    knob_levels_t knobs;
    logic [3:0]   amp_shift;      // sample gets amp_shift+1 random bits
    logic [15:0]  ticks;
  } row_t;

  logic         clk_i;
  logic         srst_i;
  logic         sample_tick_i;
  logic [1:0]   buttons_i;
  knob_levels_t knobs_i;
  sample_t      data_i;
  sample_t      data_o;
  logic [3:0]   leds_o;

  row_t  rows [NUM_ROWS];
  string names [NUM_ROWS];
  int    n_rows;

  //******************************
  // model state
  logic [15:0] lfsr_q;
  bit          bank_left;             // expected tremolo enable
  bit          bank_right;            // expected echo enable
  int          m_hist [ECHO_DEPTH];   // echo buffer, indexed by write count
  int          m_writes;              // writes since reset
  int          m_echo_time;           // active echo time in samples
  int          m_hold;                // ticks since last time reload
  logic [15:0] m_phase;               // tremolo lfo phase
  int          m_echo_prev;           // echo output of the previous tick
  int          m_expect;              // expected data_o
  int          sat_hits;              // expected outputs sitting on a limit

  pedalboard DUT (
    .clk_i         ( clk_i         ),
    .srst_i        ( srst_i        ),
    .sample_tick_i ( sample_tick_i ),
    .buttons_i     ( buttons_i     ),
    .knobs_i       ( knobs_i       ),
    .data_i        ( data_i        ),
    .data_o        ( data_o        ),
    .leds_o        ( leds_o        )
  );

  initial
  begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  //******************************
  // reporting
  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Checks failed");
    $fatal(1);
  endtask

  // four-state compare, an unknown output never matches
  task automatic check_value(input string test, input logic signed [31:0] expected,
                             input logic signed [31:0] actual);
    if (expected !== actual)
      fail_run($sformatf("mismatch %s expected %0d actual %0d", test, expected, actual));
  endtask

  //******************************
  // random samples
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    if (state[0])
      return (state >> 1) ^ LFSR_TAPS;
    else
      return state >> 1;
  endfunction

  task automatic take_sample(input int amp, output sample_t smp);
    logic [15:0] raw;
    int          val;
    int          i;
    raw = '0;
    for (i = 0; i <= amp; i++)
    begin
      raw    = {raw[14:0], lfsr_q[0]};  // one step per bit
      lfsr_q = lfsr_next(lfsr_q);
    end
    val = int'(raw);
    if (raw[amp])
      val = val - (1 << (amp + 1));     // sign from the top random bit
    smp = sample_t'(val);
  endtask

  //******************************
  // reference model
  function automatic int clamp_sample(input int v);
    if (v > MAX_SAMPLE)
      return MAX_SAMPLE;
    if (v < MIN_SAMPLE)
      return MIN_SAMPLE;
    return v;
  endfunction

  // echo with feedback, one call per tick
  task automatic echo_model(input int x, input bit en, input int level, input int knob_time,
                            output int y);
    int wet;
    wet = 0;
    if (m_echo_time <= m_writes)
      wet = m_hist[(m_writes - m_echo_time) % ECHO_DEPTH];  // time writes ago
    if (m_hold == TIME_HOLD_TICKS - 1)
      m_echo_time = knob_time;             // reload only on wrap
    m_hold = (m_hold + 1) % TIME_HOLD_TICKS;
    if (en)
      y = clamp_sample(x + ((wet * level) >>> 8));
    else
      y = x;
    m_hist[m_writes % ECHO_DEPTH] = en ? y : 0;  // disabled writes zeros
    m_writes++;
  endtask

  // triangle tremolo, gain from the phase before the step
  task automatic trem_model(input int x, input bit en, input int speed, input int depth,
                            output int y);
    logic [7:0] tri_val;
    int         gain;
    if (!en)
    begin
      m_phase = '0;
      y       = x;
    end
    else
    begin
      tri_val = m_phase[15] ? ~m_phase[14:7] : m_phase[14:7];
      gain    = 255 - ((depth * tri_val) >> 8);
      y       = (x * gain) >>> 8;
      m_phase = m_phase + 16'(speed) + 16'd1;
    end
  endtask

  //******************************
  // stimulus helpers
  task automatic add_row(input string name, input int lp, input int rp, input int dt,
                         input int dl, input int ts, input int td, input int amp,
                         input int ticks);
    row_t row;
    row.left_presses     = 4'(lp);
    row.right_presses    = 4'(rp);
    row.knobs.del_time   = 8'(dt);
    row.knobs.del_level  = 8'(dl);
    row.knobs.trem_speed = 8'(ts);
    row.knobs.trem_depth = 8'(td);
    row.amp_shift        = 4'(amp);
    row.ticks            = 16'(ticks);
    rows[n_rows]  = row;
    names[n_rows] = name;
    n_rows++;
  endtask

  // one footswitch press, held past the toggle
  task automatic press_button(input int idx, input string test);
    logic [3:0] want;
    int         wait_cnt;
    if (idx == 0)
      bank_left = !bank_left;
    else
      bank_right = !bank_right;
    want = {bank_right, bank_right, bank_left, bank_left};
    @(negedge clk_i);
    buttons_i[idx] = 1'b1;
    wait_cnt = 0;
    while (leds_o !== want && wait_cnt < LED_TIMEOUT)
    begin
      @(negedge clk_i);
      wait_cnt++;
    end
    if (leds_o !== want)
      fail_run($sformatf("leds never followed footswitch %0d in %s", idx, test));
    repeat (HOLD_CYCLES) @(negedge clk_i);
    check_value({test, " leds held"}, want, leds_o);  // no second toggle
    buttons_i[idx] = 1'b0;
    repeat (3) @(negedge clk_i);
    check_value({test, " leds"}, want, leds_o);
  endtask

  // check the last output, then issue one sample
  task automatic step_tick(input string test, input int amp);
    sample_t smp;
    int      trem_out;
    repeat (TICK_CLOCKS - 2) @(negedge clk_i);
    check_value(test, m_expect, data_o);
    @(negedge clk_i);
    take_sample(amp, smp);
    sample_tick_i = 1'b1;
    data_i        = smp;
    // tremolo sees the echo result of the previous tick
    trem_model(m_echo_prev, bank_left, knobs_i.trem_speed, knobs_i.trem_depth, trem_out);
    echo_model(smp, bank_right, knobs_i.del_level, (knobs_i.del_time + 1) * 4, m_echo_prev);
    m_expect = trem_out;
    if (m_expect == MAX_SAMPLE || m_expect == MIN_SAMPLE)
      sat_hits++;
    @(negedge clk_i);
    sample_tick_i = 1'b0;
  endtask

  //******************************
  // main sequence
  initial
  begin
    int r;
    int t;
    srst_i           = 1'b1;
    sample_tick_i    = 1'b0;
    buttons_i        = '0;
    knobs_i          = '0;
    knobs_i.del_time = 8'(INIT_DEL_TIME);  // loaded into the echo at reset
    data_i           = '0;
    lfsr_q           = LFSR_SEED;
    bank_left        = 1'b0;
    bank_right       = 1'b0;
    m_writes         = 0;
    m_echo_time      = (INIT_DEL_TIME + 1) * 4;
    m_hold           = 0;
    m_phase          = '0;
    m_echo_prev      = 0;
    m_expect         = 0;
    sat_hits         = 0;
    n_rows           = 0;

    //      name          L  R  time lvl  spd  dep amp ticks
    add_row("bypass",     0, 0,   7, 128,  10, 200, 12,  20);
    add_row("echo_short", 0, 1,   3, 100,   0,   0, 12, 150);
    add_row("echo_time",  0, 0,  40, 160,   0,   0, 12, 300);
    add_row("echo_sat",   0, 0,   2, 255,   0,   0, 15, 200);
    add_row("trem_slow",  1, 1,   2, 255, 100, 128, 13, 150);
    add_row("trem_fast",  2, 0,   2, 255, 255, 255, 14, 300);
    add_row("cascade",    0, 1,   5, 200,  60, 180, 12, 200);
    add_row("echo_off",   0, 1,   5, 200,  60, 180, 12, 100);
    add_row("echo_back",  0, 1,   5, 200,  60, 180, 12, 100);

    repeat (RESET_CYCLES) @(posedge clk_i);  // reset seen by four rising edges
    @(negedge clk_i);
    srst_i = 1'b0;
    @(negedge clk_i);
    check_value("reset leds", 0, leds_o);
    check_value("reset data", 0, data_o);

    for (r = 0; r < n_rows; r++)
    begin
      repeat (rows[r].left_presses) press_button(0, names[r]);
      repeat (rows[r].right_presses) press_button(1, names[r]);
      if (rows[r].left_presses != 0)
        m_phase = '0;                     // lfo passed through disabled
      @(negedge clk_i);
      knobs_i = rows[r].knobs;
      for (t = 0; t < rows[r].ticks; t++)
        step_tick(names[r], rows[r].amp_shift);
      repeat (3) @(negedge clk_i);
      check_value({names[r], " last"}, m_expect, data_o);
    end

    if (sat_hits == 0)
      fail_run("echo output never reached a saturation limit");
    else
    begin
      $display("All checks passed");
      $finish;
    end
  end

endmodule

// ==== pedalboard.f ====
design/pedalboard_pkg.sv
design/footswitch_ctrl.sv
design/echo_delay.sv
design/tremolo.sv
design/pedalboard.sv
bench/pedalboard_tb.sv

// ==== Bender.yml ====
package:
  name: pedalboard

sources:
  # package first, then leaf modules, then the top level
  - design/pedalboard_pkg.sv
  - design/footswitch_ctrl.sv
  - design/echo_delay.sv
  - design/tremolo.sv
  - design/pedalboard.sv

  - target: test
    files:
      - bench/pedalboard_tb.sv
